/* nf_soc.f */
rtl/nf_pkg.sv
rtl/nf_ahb_if.sv
rtl/nf_ahb_master.sv
rtl/nf_ahb_router.sv
rtl/nf_ahb_ram.sv
rtl/nf_ahb_gpio.sv
rtl/nf_ahb_pwm.sv
rtl/nf_top.sv
testbench/nf_top_tb.sv

/* rtl/nf_ahb_gpio.sv */
// GPIO slave, output and direction registers plus input pin read
// input pins are read as is, no synchronizer stage
`timescale 1ns/1ns

module nf_ahb_gpio (
    input   logic                                   clk,        // clock
    input   logic                                   rst_n_i,    // sync reset, active low
    nf_ahb_if.slave                                 bus,        // AHB slave side
    input   logic   [nf_pkg::NF_GPIO_WIDTH-1 : 0]   gpi_i,      // input pins
    output  logic   [nf_pkg::NF_GPIO_WIDTH-1 : 0]   gpo_o,      // output register
    output  logic   [nf_pkg::NF_GPIO_WIDTH-1 : 0]   gpd_o       // direction register
);
    import nf_pkg::*;

    logic   [NF_OFF_W-1 : 0]    off_r;      // sampled register offset
    logic                       wr_pend;    // write data phase next
    logic                       sel;

    assign sel = bus.hsel && (bus.htrans == NONSEQ);

    always_ff @(posedge clk) begin
        if (sel) off_r <= bus.haddr[NF_OFF_W-1 : 0];
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_pend <= 1'b0;
            gpo_o   <= '0;
            gpd_o   <= '0;
        end else begin
            wr_pend <= sel && bus.hwrite;
            if (wr_pend) begin
                case (off_r)
                    NF_GPIO_GPO_OFF : gpo_o <= bus.hwdata[NF_GPIO_WIDTH-1 : 0];
                    NF_GPIO_GPD_OFF : gpd_o <= bus.hwdata[NF_GPIO_WIDTH-1 : 0];
                    default         : ;     // input pins are read only
                endcase
            end
        end
    end

    always_comb begin
        case (off_r)
            NF_GPIO_GPI_OFF : bus.hrdata = 32'(gpi_i);  // zero above the port
            NF_GPIO_GPO_OFF : bus.hrdata = 32'(gpo_o);
            NF_GPIO_GPD_OFF : bus.hrdata = 32'(gpd_o);
            default         : bus.hrdata = '0;
        endcase
    end

    assign bus.hready = 1'b1;
    assign bus.hresp  = 1'b0;

endmodule : nf_ahb_gpio

/* rtl/nf_ahb_if.sv */
// AHB-Lite signal bundle, single master, zero-wait slaves
// hsel is driven from the master side as the fabric select
`timescale 1ns/1ns

interface nf_ahb_if;
    import nf_pkg::*;

    logic       [31 : 0]    haddr;      // address phase address
    logic       [31 : 0]    hwdata;     // data phase write data
    logic       [31 : 0]    hrdata;     // data phase read data
    logic                   hwrite;     // 1 = write
    nf_htrans_e             htrans;     // IDLE or NONSEQ
    logic                   hsel;       // slave select
    logic                   hready;     // transfer done
    logic                   hresp;      // 1 = error

    modport master (
        output  haddr, hwdata, hwrite, htrans, hsel,
        input   hrdata, hready, hresp
    );

    modport slave (
        input   haddr, hwdata, hwrite, htrans, hsel,
        output  hrdata, hready, hresp
    );

endinterface : nf_ahb_if

/* rtl/nf_ahb_master.sv */
// core req/req_ack to AHB-Lite bridge, one transfer in flight
// fixed 2 cycle latency from accepted req_i to req_ack_o with zero-wait slaves
`timescale 1ns/1ns

module nf_ahb_master (
    input   logic               clk,        // clock
    input   logic               rst_n_i,    // sync reset, active low
    input   logic   [31 : 0]    addr_i,     // core address
    input   logic   [31 : 0]    wd_i,       // core write data
    input   logic               we_i,       // core write enable
    input   logic               req_i,      // core request
    output  logic   [31 : 0]    rd_o,       // read data, valid with ack
    output  logic               req_ack_o,  // one cycle ack
    output  logic               err_o,      // unmapped access, valid with ack
    nf_ahb_if.master            ahb         // AHB master side
);
    import nf_pkg::*;

    typedef enum logic [1 : 0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA
    } state_e;

    state_e             state;          // current phase
    state_e             state_nxt;      // next phase
    logic   [31 : 0]    addr_r;         // latched request
    logic   [31 : 0]    wd_r;
    logic               we_r;
    logic               take_req;       // request accepted this cycle

    // new request from idle, or chained on the ack cycle
    assign take_req = req_i && ((state == ST_IDLE) || ((state == ST_DATA) && ahb.hready));

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE : if (req_i) state_nxt = ST_ADDR;
            ST_ADDR : state_nxt = ST_DATA;                          // slave samples here
            ST_DATA : if (ahb.hready) state_nxt = req_i ? ST_ADDR : ST_IDLE;
            default : state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (take_req) begin
            addr_r <= addr_i;   // hold for both phases
            wd_r   <= wd_i;
            we_r   <= we_i;
        end
    end

    assign ahb.haddr  = addr_r;
    assign ahb.hwrite = we_r;
    assign ahb.hwdata = wd_r;                                       // sampled only in data phase
    assign ahb.htrans = (state == ST_ADDR) ? NONSEQ : IDLE;
    assign ahb.hsel   = (state == ST_ADDR);                         // fabric select

    // data phase result goes straight to the core with the ack
    assign req_ack_o = (state == ST_DATA) && ahb.hready;
    assign err_o     = req_ack_o && ahb.hresp;
    assign rd_o      = ahb.hrdata;

endmodule : nf_ahb_master

/* rtl/nf_ahb_pwm.sv */
// PWM slave, free running counter wrapping every 256 cycles
// duty 0 keeps pwm_o low, the output is one cycle behind the compare
`timescale 1ns/1ns

module nf_ahb_pwm (
    input   logic       clk,        // clock
    input   logic       rst_n_i,    // sync reset, active low
    nf_ahb_if.slave     bus,        // AHB slave side
    output  logic       pwm_o       // registered pwm output
);
    import nf_pkg::*;

    logic   [NF_PWM_WIDTH-1 : 0]    duty_r;     // high cycles per period
    logic   [NF_PWM_WIDTH-1 : 0]    cnt;        // period counter
    logic   [NF_OFF_W-1 : 0]        off_r;      // sampled register offset
    logic                           wr_pend;
    logic                           sel;

    assign sel = bus.hsel && (bus.htrans == NONSEQ);

    always_ff @(posedge clk) begin
        if (sel) off_r <= bus.haddr[NF_OFF_W-1 : 0];
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_pend <= 1'b0;
            duty_r  <= '0;
            cnt     <= '0;
            pwm_o   <= 1'b0;
        end else begin
            wr_pend <= sel && bus.hwrite;
            if (wr_pend && (off_r == NF_PWM_DUTY_OFF)) duty_r <= bus.hwdata[NF_PWM_WIDTH-1 : 0];
            cnt     <= cnt + NF_PWM_WIDTH'(1);  // wraps on its own
            pwm_o   <= (cnt < duty_r);
        end
    end

    assign bus.hrdata = (off_r == NF_PWM_DUTY_OFF) ? 32'(duty_r) : '0;
    assign bus.hready = 1'b1;
    assign bus.hresp  = 1'b0;

endmodule : nf_ahb_pwm

/* rtl/nf_ahb_ram.sv */
// word RAM slave, zero wait, word index from address bits 9:2
// no preload, contents are undefined until written
`timescale 1ns/1ns

module nf_ahb_ram (
    input   logic       clk,        // clock
    input   logic       rst_n_i,    // sync reset, active low
    nf_ahb_if.slave     bus         // AHB slave side
);
    import nf_pkg::*;

    logic   [31 : 0]            mem [NF_RAM_DEPTH];     // storage array
    logic   [NF_RAM_AW-1 : 0]   idx_r;                  // sampled word index
    logic                       wr_pend;                // write data phase next
    logic                       sel;                    // address phase for us

    assign sel = bus.hsel && (bus.htrans == NONSEQ);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_pend <= 1'b0;
        end else begin
            wr_pend <= sel && bus.hwrite;
        end
    end

    always_ff @(posedge clk) begin
        if (sel) begin
            idx_r <= bus.haddr[NF_RAM_AW+1 : 2];        // word aligned
        end
    end

    // write lands at the end of the data phase
    always_ff @(posedge clk) begin
        if (wr_pend) begin
            mem[idx_r] <= bus.hwdata;
        end
    end

    assign bus.hrdata = mem[idx_r];     // async read of sampled word
    assign bus.hready = 1'b1;           // never stalls
    assign bus.hresp  = 1'b0;

endmodule : nf_ahb_ram

/* rtl/nf_ahb_router.sv */
// address decoder and response mux for the three zero-wait slaves
// unmapped transfers get hresp 1 and zero read data from the router itself
`timescale 1ns/1ns

module nf_ahb_router (
    input   logic       clk,                            // clock
    input   logic       rst_n_i,                        // sync reset, active low
    nf_ahb_if.slave     mst,                            // from the bridge
    nf_ahb_if.master    slv [nf_pkg::NF_SLAVE_COUNT]    // to the slaves
);
    import nf_pkg::*;

    logic               xfer;                           // address phase active
    logic               sel_vld;                        // address hits a region
    nf_slave_e          sel_idx;                        // decoded slave
    nf_slave_e          dp_idx;                         // slave of the data phase
    logic               dp_err;                         // data phase is unmapped
    logic   [31 : 0]    s_rdata [NF_SLAVE_COUNT];
    logic               s_ready [NF_SLAVE_COUNT];
    logic               s_resp  [NF_SLAVE_COUNT];

    assign xfer = mst.hsel && (mst.htrans == NONSEQ);

    always_comb begin
        sel_vld = 1'b0;
        sel_idx = SLV_RAM;                              // keeps dp_idx in range
        if (mst.haddr[31 : 18] == '0) begin
            case (mst.haddr[17 : 16])
                NF_RAM_BASE[17 : 16]  : begin sel_vld = 1'b1; sel_idx = SLV_RAM;  end
                NF_GPIO_BASE[17 : 16] : begin sel_vld = 1'b1; sel_idx = SLV_GPIO; end
                NF_PWM_BASE[17 : 16]  : begin sel_vld = 1'b1; sel_idx = SLV_PWM;  end
                default               : sel_vld = 1'b0;  // bits 17:16 = 3
            endcase
        end
    end

    // address phase fans out, hsel only to the hit slave
    for (genvar i = 0; i < NF_SLAVE_COUNT; i++) begin : g_slv
        assign slv[i].haddr  = mst.haddr;
        assign slv[i].hwdata = mst.hwdata;
        assign slv[i].hwrite = mst.hwrite;
        assign slv[i].htrans = mst.htrans;
        assign slv[i].hsel   = xfer && sel_vld && (sel_idx == nf_slave_e'(i));
        assign s_rdata[i]    = slv[i].hrdata;
        assign s_ready[i]    = slv[i].hready;
        assign s_resp[i]     = slv[i].hresp;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            dp_idx <= SLV_RAM;
            dp_err <= 1'b0;
        end else begin
            if (xfer && sel_vld) dp_idx <= sel_idx;     // steer the next data phase
            dp_err <= xfer && !sel_vld;
        end
    end

    assign mst.hrdata = dp_err ? '0   : s_rdata[dp_idx];
    assign mst.hresp  = dp_err ? 1'b1 : s_resp[dp_idx];
    assign mst.hready = dp_err ? 1'b1 : s_ready[dp_idx];

endmodule : nf_ahb_router

/* rtl/nf_pkg.sv */
// address map, widths and AHB transfer types for the peripheral subsystem
// single-word transfers only, no bursts and no byte or halfword sizes
package nf_pkg;

    localparam int NF_GPIO_WIDTH  = 8;                      // gpio port width
    localparam int NF_PWM_WIDTH   = 8;                      // pwm counter and duty width
    localparam int NF_RAM_DEPTH   = 256;                    // ram words
    localparam int NF_RAM_AW      = $clog2(NF_RAM_DEPTH);   // ram word index width
    localparam int NF_SLAVE_COUNT = 3;                      // ram, gpio, pwm
    localparam int NF_OFF_W       = 16;                     // register offset width in a region

    // region bases, decoded on bits 17:16 with bits 31:18 zero
    localparam logic [31 : 0] NF_RAM_BASE  = 32'h0000_0000;
    localparam logic [31 : 0] NF_GPIO_BASE = 32'h0001_0000;
    localparam logic [31 : 0] NF_PWM_BASE  = 32'h0002_0000;

    // register offsets within a region
    localparam logic [NF_OFF_W-1 : 0] NF_GPIO_GPI_OFF = 16'h0000;  // input pins, read only
    localparam logic [NF_OFF_W-1 : 0] NF_GPIO_GPO_OFF = 16'h0004;  // output register
    localparam logic [NF_OFF_W-1 : 0] NF_GPIO_GPD_OFF = 16'h0008;  // direction register
    localparam logic [NF_OFF_W-1 : 0] NF_PWM_DUTY_OFF = 16'h0000;  // duty register

    // AHB HTRANS, only the two codes used here
    typedef enum logic [1 : 0] {
        IDLE   = 2'b00,
        NONSEQ = 2'b10
    } nf_htrans_e;

    // slave index, also the router port number
    typedef enum logic [1 : 0] {
        SLV_RAM  = 2'd0,
        SLV_GPIO = 2'd1,
        SLV_PWM  = 2'd2
    } nf_slave_e;

endpackage : nf_pkg

/* rtl/nf_top.sv */
// peripheral subsystem top, core data port as plain ports
// one request in flight, ack 2 cycles after req_i is taken
`timescale 1ns/1ns

module nf_top (
    input   logic                                   clk,        // clock
    input   logic                                   rst_n_i,    // sync reset, active low
    input   logic   [31 : 0]                        addr_i,     // core address
    input   logic   [31 : 0]                        wd_i,       // core write data
    input   logic                                   we_i,       // core write enable
    input   logic                                   req_i,      // core request
    output  logic   [31 : 0]                        rd_o,       // read data
    output  logic                                   req_ack_o,  // request ack
    output  logic                                   err_o,      // unmapped access
    input   logic   [nf_pkg::NF_GPIO_WIDTH-1 : 0]   gpio_i_i,   // gpio input pins
    output  logic   [nf_pkg::NF_GPIO_WIDTH-1 : 0]   gpio_o_o,   // gpio output
    output  logic   [nf_pkg::NF_GPIO_WIDTH-1 : 0]   gpio_d_o,   // gpio direction
    output  logic                                   pwm_o       // pwm output
);
    import nf_pkg::*;

    nf_ahb_if mst_bus ();                       // bridge to router
    nf_ahb_if slv_bus [NF_SLAVE_COUNT] ();      // router to slaves

    nf_ahb_master nf_ahb_master_0 (
        .clk        ( clk       ),
        .rst_n_i    ( rst_n_i   ),
        .addr_i     ( addr_i    ),
        .wd_i       ( wd_i      ),
        .we_i       ( we_i      ),
        .req_i      ( req_i     ),
        .rd_o       ( rd_o      ),
        .req_ack_o  ( req_ack_o ),
        .err_o      ( err_o     ),
        .ahb        ( mst_bus   )
    );

    nf_ahb_router nf_ahb_router_0 (
        .clk        ( clk       ),
        .rst_n_i    ( rst_n_i   ),
        .mst        ( mst_bus   ),
        .slv        ( slv_bus   )
    );

    nf_ahb_ram nf_ahb_ram_0 (
        .clk        ( clk               ),
        .rst_n_i    ( rst_n_i           ),
        .bus        ( slv_bus[SLV_RAM]  )
    );

    nf_ahb_gpio nf_ahb_gpio_0 (
        .clk        ( clk               ),
        .rst_n_i    ( rst_n_i           ),
        .bus        ( slv_bus[SLV_GPIO] ),
        .gpi_i      ( gpio_i_i          ),
        .gpo_o      ( gpio_o_o          ),
        .gpd_o      ( gpio_d_o          )
    );

    nf_ahb_pwm nf_ahb_pwm_0 (
        .clk        ( clk               ),
        .rst_n_i    ( rst_n_i           ),
        .bus        ( slv_bus[SLV_PWM]  ),
        .pwm_o      ( pwm_o             )
    );

endmodule : nf_top

/* run_sim.sh */
#!/bin/sh
# build and run the nf_soc simulation with Verilator
# run from the project root

LOG=sim.log

verilator --binary --timing -f nf_soc.f --top-module nf_top_tb \
    --Mdir obj_dir -o nf_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/nf_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0

/* testbench/nf_top_tb.sv */
// directed tests for the peripheral subsystem, the testbench acts as the core
// every request must be acked exactly 2 cycles after it is raised
`timescale 1ns/1ns

module nf_top_tb;
    import nf_pkg::*;

    localparam int MAX_CYCLES = 4000;   // about 50 transfers, two 256 cycle pwm windows, margin

    logic                           clk;
    logic                           rst_n_i;
    logic   [31 : 0]                addr_i;
    logic   [31 : 0]                wd_i;
    logic                           we_i;
    logic                           req_i;
    logic   [31 : 0]                rd_o;
    logic                           req_ack_o;
    logic                           err_o;
    logic   [NF_GPIO_WIDTH-1 : 0]   gpio_i_i;
    logic   [NF_GPIO_WIDTH-1 : 0]   gpio_o_o;
    logic   [NF_GPIO_WIDTH-1 : 0]   gpio_d_o;
    logic                           pwm_o;

    int                 mismatch_cnt = 0;   // wrong values
    int                 other_cnt    = 0;   // wrong ack timing
    int                 cycle_cnt    = 0;
    logic   [15 : 0]    lfsr_q       = 16'd33;
    logic   [7 : 0]     ram_idx [16];       // word indices of the ram test
    logic   [31 : 0]    ram_val [16];

    nf_top u_dut (.*);

    always #4 clk = ~clk;   // 8 ns period

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("run stopped, no end of test after %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    // fibonacci lfsr x^16+x^14+x^13+x^11+1, one step per bit
    function automatic logic [31 : 0] next_bits(input int n);
        logic   [31 : 0]    val;
        logic               fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14 : 0], fb};
            val    = {val[30 : 0], fb};
        end
        return val;
    endfunction

    task automatic check_data(input string what, input logic [31 : 0] got,
                              input logic [31 : 0] exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch at %0t ns: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // raise req_i, wait for the ack, check latency and error flag
    task automatic run_request(input logic [31 : 0] addr, input logic we,
                               input logic [31 : 0] wd, input logic exp_err,
                               input bit keep, output logic [31 : 0] rd);
        int cycles;
        addr_i = addr;
        we_i   = we;
        wd_i   = wd;
        req_i  = 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!req_ack_o);
        if (cycles != 2) begin
            other_cnt++;
            $display("ack for address %h came %0d cycles after the request, not 2",
                     addr, cycles);
        end
        rd = rd_o;                                      // valid in the ack cycle
        check_flag("err_o", err_o, exp_err);
        if (!keep) req_i = 1'b0;                        // keep high to chain
    endtask

    task automatic bus_write(input logic [31 : 0] addr, input logic [31 : 0] data,
                             input logic exp_err, input bit keep);
        logic   [31 : 0]    unused_rd;
        run_request(addr, 1'b1, data, exp_err, keep, unused_rd);
    endtask

    task automatic bus_read(input logic [31 : 0] addr, output logic [31 : 0] data,
                            input logic exp_err, input bit keep);
        run_request(addr, 1'b0, 32'h0, exp_err, keep, data);
    endtask

    task automatic test_ram();
        logic   [31 : 0]    rd;
        logic   [31 : 0]    top_val;
        for (int i = 0; i < 16; i++) begin
            ram_idx[i] = 8'((i * 37 + 5) % 256);       // scattered word indices
            ram_val[i] = next_bits(32);
            bus_write(NF_RAM_BASE + 32'(ram_idx[i]) * 4, ram_val[i], 1'b0, 1'b0);
        end
        for (int i = 15; i >= 0; i--) begin             // reverse order
            bus_read(NF_RAM_BASE + 32'(ram_idx[i]) * 4, rd, 1'b0, 1'b0);
            check_data("ram word", rd, ram_val[i]);
        end
        top_val = next_bits(32);
        bus_write(NF_RAM_BASE + 32'd255 * 4, top_val, 1'b0, 1'b0);
        bus_read(NF_RAM_BASE + 32'd255 * 4, rd, 1'b0, 1'b0);
        check_data("ram word 255", rd, top_val);
    endtask

    task automatic test_gpio_out();
        logic   [31 : 0]    rd;
        logic   [7 : 0]     out_val;
        logic   [7 : 0]     dir_val;
        out_val = 8'(next_bits(8));
        dir_val = 8'(next_bits(8));
        bus_write(NF_GPIO_BASE + 32'(NF_GPIO_GPO_OFF), 32'(out_val), 1'b0, 1'b0);
        @(posedge clk);                                 // register loads at end of ack cycle
        #1;
        check_data("gpio_o_o", 32'(gpio_o_o), 32'(out_val));
        bus_write(NF_GPIO_BASE + 32'(NF_GPIO_GPD_OFF), 32'(dir_val), 1'b0, 1'b0);
        @(posedge clk);
        #1;
        check_data("gpio_d_o", 32'(gpio_d_o), 32'(dir_val));
        bus_read(NF_GPIO_BASE + 32'(NF_GPIO_GPO_OFF), rd, 1'b0, 1'b0);
        check_data("gpio output reg", rd, {24'h0, out_val});
        bus_read(NF_GPIO_BASE + 32'(NF_GPIO_GPD_OFF), rd, 1'b0, 1'b0);
        check_data("gpio direction reg", rd, {24'h0, dir_val});
    endtask

    task automatic test_gpio_in();
        logic   [31 : 0]    rd;
        logic   [7 : 0]     pin_val;
        pin_val  = 8'(next_bits(8));
        gpio_i_i = pin_val;
        bus_read(NF_GPIO_BASE + 32'(NF_GPIO_GPI_OFF), rd, 1'b0, 1'b0);
        check_data("gpio input pins", rd, {24'h0, pin_val});
    endtask

    // high cycles of pwm_o over one full counter period
    task automatic count_pwm_high(output int highs);
        highs = 0;
        repeat (256) begin
            @(posedge clk);
            #1;
            if (pwm_o) highs++;
        end
    endtask

    task automatic test_pwm();
        logic   [31 : 0]    rd;
        int                 highs;
        bus_write(NF_PWM_BASE + 32'(NF_PWM_DUTY_OFF), 32'h40, 1'b0, 1'b0);
        bus_read(NF_PWM_BASE + 32'(NF_PWM_DUTY_OFF), rd, 1'b0, 1'b0);  // also lets pwm_o settle
        check_data("pwm duty", rd, 32'h40);
        count_pwm_high(highs);
        check_data("pwm high cycles, duty 0x40", 32'(highs), 32'd64);
        bus_write(NF_PWM_BASE + 32'(NF_PWM_DUTY_OFF), 32'h0, 1'b0, 1'b0);
        bus_read(NF_PWM_BASE + 32'(NF_PWM_DUTY_OFF), rd, 1'b0, 1'b0);
        check_data("pwm duty", rd, 32'h0);
        count_pwm_high(highs);
        check_data("pwm high cycles, duty 0", 32'(highs), 32'd0);
    endtask

    task automatic test_unmapped();
        logic   [31 : 0]    rd;
        logic   [31 : 0]    word0_val;
        word0_val = next_bits(32);
        bus_write(NF_RAM_BASE, word0_val, 1'b0, 1'b0);  // same bits 9:2 as both unmapped addresses
        bus_read(32'h0003_0000, rd, 1'b1, 1'b0);
        check_data("unmapped read", rd, 32'h0);
        bus_write(32'h1000_0000, 32'hdead_beef, 1'b1, 1'b0);
        bus_read(NF_RAM_BASE, rd, 1'b0, 1'b0);          // ram untouched
        check_data("ram after unmapped", rd, word0_val);
    endtask

    task automatic test_back_to_back();
        logic   [31 : 0]    rd;
        logic   [31 : 0]    val;
        val = next_bits(32);
        bus_write(NF_RAM_BASE + 32'd100 * 4, val, 1'b0, 1'b1);    // req_i stays high
        bus_read(NF_RAM_BASE + 32'd100 * 4, rd, 1'b0, 1'b0);
        check_data("chained read", rd, val);
    endtask

    initial begin
        clk      = 1'b0;
        rst_n_i  = 1'b0;
        addr_i   = '0;
        wd_i     = '0;
        we_i     = 1'b0;
        req_i    = 1'b0;
        gpio_i_i = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        check_flag("req_ack_o after reset", req_ack_o, 1'b0);
        check_flag("err_o after reset", err_o, 1'b0);
        check_data("gpio_o_o after reset", 32'(gpio_o_o), 32'h0);
        check_data("gpio_d_o after reset", 32'(gpio_d_o), 32'h0);
        check_flag("pwm_o after reset", pwm_o, 1'b0);
        test_ram();
        test_gpio_out();
        test_gpio_in();
        test_pwm();
        test_unmapped();
        test_back_to_back();
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if ((mismatch_cnt == 0) && (other_cnt == 0)) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : nf_top_tb
